// ==== source/udp_rx_consts.svh ====
// Slot count must stay a power of two because ring pointers wrap by width; payload limit is SLOT_WORDS words of 8 bytes
`ifndef UDP_RX_CONSTS_SVH
`define UDP_RX_CONSTS_SVH

// Ring geometry
`define UDP_RX_SLOTS        4
`define UDP_RX_SLOT_IDX_W   2
`define UDP_RX_SLOT_WORDS   8
`define UDP_RX_WORD_IDX_W   3
`define UDP_RX_COUNT_W      3

// Largest payload a slot can hold, in bytes
`define UDP_RX_MAX_PAYLOAD  (`UDP_RX_SLOT_WORDS * 8)

// UDP header length, removed from the length field
`define UDP_RX_HDR_BYTES    8

// Register bus
`define UDP_RX_AXIL_AW      8
`define UDP_RX_AXIL_DW      32

// Payload stream width
`define UDP_RX_BEAT_W       64

`endif

// ==== source/udp_rx_pkg.sv ====
// Types shared by the receive path; field widths come from the constants header
`default_nettype none

`include "udp_rx_consts.svh"

package udp_rx_pkg;

    // Parsed UDP/IP header as delivered by the framing logic
    typedef struct packed {
        logic [31:0] src_ip;
        logic [15:0] src_port;
        logic [31:0] dst_ip;
        logic [15:0] dst_port;
        logic [15:0] length;
    } udp_hdr_t;

    typedef struct packed {
        logic [`UDP_RX_BEAT_W-1:0] data;
        logic                      last;
    } udp_beat_t;

    // Manager to subordinate half of AXI4-Lite
    typedef struct packed {
        logic [`UDP_RX_AXIL_AW-1:0]   awaddr;
        logic                         awvalid;
        logic [`UDP_RX_AXIL_DW-1:0]   wdata;
        logic [`UDP_RX_AXIL_DW/8-1:0] wstrb;
        logic                         wvalid;
        logic                         bready;
        logic [`UDP_RX_AXIL_AW-1:0]   araddr;
        logic                         arvalid;
        logic                         rready;
    } axil_req_t;

    typedef struct packed {
        logic                       awready;
        logic                       wready;
        logic [1:0]                 bresp;
        logic                       bvalid;
        logic                       arready;
        logic [`UDP_RX_AXIL_DW-1:0] rdata;
        logic [1:0]                 rresp;
        logic                       rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic        enable;
        logic [31:0] local_ip;
        logic [15:0] port;
    } rx_cfg_t;

    // Word writes into the open slot, commit closes it
    typedef struct packed {
        logic                         we;
        logic [`UDP_RX_WORD_IDX_W-1:0] idx;
        logic [`UDP_RX_BEAT_W-1:0]    data;
        logic                         commit;
        udp_hdr_t                     hdr;
    } slot_wr_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CHECK,
        S_STORE,
        S_DISCARD
    } ctrl_state_e;

    // Byte offsets in the register window
    typedef enum logic [`UDP_RX_AXIL_AW-1:0] {
        CTRL        = 8'h00,
        LOCAL_IP    = 8'h04,
        STATUS      = 8'h08,
        DROPS       = 8'h0C,
        HEAD_SRC_IP = 8'h10,
        HEAD_PORTS  = 8'h14,
        HEAD_LEN    = 8'h18,
        POP         = 8'h1C,
        DATA        = 8'h40
    } csr_reg_e;

endpackage

`default_nettype wire

// ==== source/udp_rx_csr.sv ====
// AXI4-Lite slave with one outstanding read and one outstanding write; all responses are OKAY
`timescale 1ns/10ps
`default_nettype none

`include "udp_rx_consts.svh"

module udp_rx_csr (
    input  wire                                 clk,
    input  wire                                 rst_i,
    input  wire udp_rx_pkg::axil_req_t          axil_i,
    output udp_rx_pkg::axil_rsp_t               axil_o,
    output udp_rx_pkg::rx_cfg_t                 cfg_o,
    input  wire                                 drop_i,
    input  wire udp_rx_pkg::udp_hdr_t           head_hdr_i,
    input  wire [`UDP_RX_BEAT_W-1:0]            head_word_i,
    input  wire [`UDP_RX_COUNT_W-1:0]           count_i,
    output logic                                pop_o,
    output logic [`UDP_RX_WORD_IDX_W-1:0]       rd_word_o
);

    import udp_rx_pkg::*;

    logic                       aw_hs;
    logic                       ar_hs;
    logic                       bvalid_q;
    logic                       rvalid_q;
    logic [`UDP_RX_AXIL_DW-1:0] rdata_d;
    logic [`UDP_RX_AXIL_DW-1:0] rdata_q;
    logic                       enable_q;
    logic [15:0]                port_q;
    logic [31:0]                local_ip_q;
    logic [31:0]                drops_q;
    logic [31:0]                ctrl_merged;
    logic [31:0]                ip_merged;
    logic                       in_window;
    logic [`UDP_RX_AXIL_AW-1:0] win_off;

    // Byte-lane merge of a register write
    function automatic logic [31:0] merge_strb(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input logic [3:0]  strb
    );
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Address and data must arrive together
    assign aw_hs = axil_i.awvalid && axil_i.wvalid && !bvalid_q;
    assign ar_hs = axil_i.arvalid && !rvalid_q;

    assign ctrl_merged = merge_strb({port_q, 15'd0, enable_q}, axil_i.wdata, axil_i.wstrb);
    assign ip_merged   = merge_strb(local_ip_q, axil_i.wdata, axil_i.wstrb);

    assign pop_o = aw_hs && (csr_reg_e'(axil_i.awaddr) == POP);

    // Data window, two 32-bit reads per payload word
    assign in_window = (int'(axil_i.araddr) >= int'(DATA)) &&
                       (int'(axil_i.araddr) < int'(DATA) + `UDP_RX_MAX_PAYLOAD);
    assign win_off   = axil_i.araddr - DATA;
    assign rd_word_o = win_off[3 +: `UDP_RX_WORD_IDX_W];

    always_comb begin
        rdata_d = '0;
        if (in_window) begin
            rdata_d = win_off[2] ? head_word_i[63:32] : head_word_i[31:0];
        end else begin
            case (csr_reg_e'(axil_i.araddr))
                CTRL:        rdata_d = {port_q, 15'd0, enable_q};
                LOCAL_IP:    rdata_d = local_ip_q;
                STATUS:      rdata_d = 32'(count_i);
                DROPS:       rdata_d = drops_q;
                HEAD_SRC_IP: rdata_d = head_hdr_i.src_ip;
                HEAD_PORTS:  rdata_d = {head_hdr_i.src_port, head_hdr_i.dst_port};
                HEAD_LEN:    rdata_d = 32'(head_hdr_i.length);
                default:     rdata_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            bvalid_q   <= 1'b0;
            rvalid_q   <= 1'b0;
            enable_q   <= 1'b0;
            port_q     <= '0;
            local_ip_q <= '0;
            drops_q    <= '0;
        end else begin
            if (aw_hs) begin
                bvalid_q <= 1'b1;
            end else if (axil_i.bready) begin
                bvalid_q <= 1'b0;
            end

            if (ar_hs) begin
                rvalid_q <= 1'b1;
            end else if (axil_i.rready) begin
                rvalid_q <= 1'b0;
            end

            if (drop_i) begin
                drops_q <= drops_q + 32'd1;
            end

            if (aw_hs) begin
                case (csr_reg_e'(axil_i.awaddr))
                    CTRL: begin
                        enable_q <= ctrl_merged[0];
                        port_q   <= ctrl_merged[31:16];
                    end
                    LOCAL_IP: local_ip_q <= ip_merged;
                    default: ;
                endcase
            end
        end
    end

    // Read data captured at the address handshake
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_q <= rdata_d;
        end
    end

    assign axil_o.awready = aw_hs;
    assign axil_o.wready  = aw_hs;
    assign axil_o.bresp   = 2'b00;
    assign axil_o.bvalid  = bvalid_q;
    assign axil_o.arready = ar_hs;
    assign axil_o.rdata   = rdata_q;
    assign axil_o.rresp   = 2'b00;
    assign axil_o.rvalid  = rvalid_q;

    assign cfg_o.enable   = enable_q;
    assign cfg_o.local_ip = local_ip_q;
    assign cfg_o.port     = port_q;

endmodule

`default_nettype wire

// ==== source/udp_rx_ctrl.sv ====
// One datagram in flight; beat count must match the UDP length, which is not rechecked here
`timescale 1ns/10ps
`default_nettype none

`include "udp_rx_consts.svh"

module udp_rx_ctrl (
    input  wire                        clk,
    input  wire                        rst_i,
    input  wire udp_rx_pkg::rx_cfg_t   cfg_i,
    input  wire                        full_i,
    input  wire udp_rx_pkg::udp_hdr_t  hdr_i,
    input  wire                        hdr_valid_i,
    output logic                       hdr_ready_o,
    input  wire udp_rx_pkg::udp_beat_t beat_i,
    input  wire                        beat_valid_i,
    output logic                       beat_ready_o,
    output udp_rx_pkg::slot_wr_t       wr_o,
    output logic                       drop_o,
    output logic                       rx_irq_o
);

    import udp_rx_pkg::*;

    ctrl_state_e                   state_q;
    ctrl_state_e                   state_d;
    udp_hdr_t                      hdr_q;
    logic                          hdr_ready_q;
    logic [`UDP_RX_WORD_IDX_W-1:0] word_q;
    logic                          commit_q;
    logic                          drop_q;
    logic                          hdr_hs;
    logic                          beat_hs;
    logic [15:0]                   pay_len;
    logic                          accept;

    assign hdr_hs  = hdr_valid_i && hdr_ready_q;
    assign beat_hs = beat_valid_i && beat_ready_o;

    // Short length fields wrap to a large value and fail the size test
    assign pay_len = hdr_q.length - 16'(`UDP_RX_HDR_BYTES);
    assign accept  = cfg_i.enable
                  && (hdr_q.dst_ip == cfg_i.local_ip)
                  && (hdr_q.dst_port == cfg_i.port)
                  && (pay_len <= 16'(`UDP_RX_MAX_PAYLOAD))
                  && !full_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:    if (hdr_hs) state_d = S_CHECK;
            S_CHECK:   state_d = accept ? S_STORE : S_DISCARD;
            S_STORE,
            S_DISCARD: if (beat_hs && beat_i.last) state_d = S_IDLE;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= S_IDLE;
            hdr_ready_q <= 1'b0;
            word_q      <= '0;
            commit_q    <= 1'b0;
            drop_q      <= 1'b0;
        end else begin
            state_q     <= state_d;
            hdr_ready_q <= (state_d == S_IDLE);
            commit_q    <= (state_q == S_STORE) && beat_hs && beat_i.last;
            drop_q      <= (state_q == S_DISCARD) && beat_hs && beat_i.last;
            if (hdr_hs) begin
                word_q <= '0;
            end else if (beat_hs) begin
                word_q <= word_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_hs) begin
            hdr_q <= hdr_i;
        end
    end

    assign hdr_ready_o  = hdr_ready_q;
    // Never back-pressured once the decision is made
    assign beat_ready_o = (state_q == S_STORE) || (state_q == S_DISCARD);

    assign wr_o.we     = beat_hs && (state_q == S_STORE);
    assign wr_o.idx    = word_q;
    assign wr_o.data   = beat_i.data;
    assign wr_o.commit = commit_q;
    assign wr_o.hdr    = hdr_q;

    assign rx_irq_o = commit_q;
    assign drop_o   = drop_q;

endmodule

`default_nettype wire

// ==== source/udp_rx_buffer.sv ====
// Commit must only arrive when not full; words past a short payload keep stale data
`timescale 1ns/10ps
`default_nettype none

`include "udp_rx_consts.svh"

module udp_rx_buffer (
    input  wire                                clk,
    input  wire                                rst_i,
    input  wire udp_rx_pkg::slot_wr_t          wr_i,
    input  wire                                pop_i,
    input  wire [`UDP_RX_WORD_IDX_W-1:0]       rd_word_i,
    output udp_rx_pkg::udp_hdr_t               head_hdr_o,
    output logic [`UDP_RX_BEAT_W-1:0]          head_word_o,
    output logic [`UDP_RX_COUNT_W-1:0]         count_o,
    output logic                               full_o
);

    import udp_rx_pkg::*;

    localparam int DEPTH = `UDP_RX_SLOTS * `UDP_RX_SLOT_WORDS;

    logic [`UDP_RX_BEAT_W-1:0]    word_mem [DEPTH];
    udp_hdr_t                     hdr_mem  [`UDP_RX_SLOTS];
    logic [`UDP_RX_SLOT_IDX_W-1:0] wr_ptr_q;
    logic [`UDP_RX_SLOT_IDX_W-1:0] rd_ptr_q;
    logic [`UDP_RX_COUNT_W-1:0]   count_q;
    logic                         do_pop;

    // Empty ring ignores pop
    assign do_pop = pop_i && (count_q != '0);

    // Payload words go straight into the open slot
    always_ff @(posedge clk) begin
        if (wr_i.we) begin
            word_mem[{wr_ptr_q, wr_i.idx}] <= wr_i.data;
        end
        if (wr_i.commit) begin
            hdr_mem[wr_ptr_q] <= wr_i.hdr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_i.commit) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_i.commit, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Head slot is visible without a read latency
    assign head_hdr_o  = hdr_mem[rd_ptr_q];
    assign head_word_o = word_mem[{rd_ptr_q, rd_word_i}];
    assign count_o     = count_q;
    assign full_o      = (count_q == `UDP_RX_COUNT_W'(`UDP_RX_SLOTS));

endmodule

`default_nettype wire

// ==== source/udp_rx_top.sv ====
// Single clock domain; irq is a one-cycle pulse per stored datagram, no level status
`timescale 1ns/10ps
`default_nettype none

`include "udp_rx_consts.svh"

module udp_rx_top (
    input  wire                        clk,
    input  wire                        rst_i,
    input  wire udp_rx_pkg::udp_hdr_t  hdr_i,
    input  wire                        hdr_valid_i,
    output wire                        hdr_ready_o,
    input  wire udp_rx_pkg::udp_beat_t beat_i,
    input  wire                        beat_valid_i,
    output wire                        beat_ready_o,
    input  wire udp_rx_pkg::axil_req_t axil_i,
    output udp_rx_pkg::axil_rsp_t      axil_o,
    output wire                        rx_irq_o
);

    import udp_rx_pkg::*;

    rx_cfg_t                       cfg;
    logic                          drop;
    slot_wr_t                      wr;
    logic                          full;
    logic                          pop;
    logic [`UDP_RX_WORD_IDX_W-1:0] rd_word;
    udp_hdr_t                      head_hdr;
    logic [`UDP_RX_BEAT_W-1:0]     head_word;
    logic [`UDP_RX_COUNT_W-1:0]    count;

    udp_rx_csr u_csr (
        .clk         (clk),
        .rst_i       (rst_i),
        .axil_i      (axil_i),
        .axil_o      (axil_o),
        .cfg_o       (cfg),
        .drop_i      (drop),
        .head_hdr_i  (head_hdr),
        .head_word_i (head_word),
        .count_i     (count),
        .pop_o       (pop),
        .rd_word_o   (rd_word)
    );

    udp_rx_ctrl u_ctrl (
        .clk          (clk),
        .rst_i        (rst_i),
        .cfg_i        (cfg),
        .full_i       (full),
        .hdr_i        (hdr_i),
        .hdr_valid_i  (hdr_valid_i),
        .hdr_ready_o  (hdr_ready_o),
        .beat_i       (beat_i),
        .beat_valid_i (beat_valid_i),
        .beat_ready_o (beat_ready_o),
        .wr_o         (wr),
        .drop_o       (drop),
        .rx_irq_o     (rx_irq_o)
    );

    udp_rx_buffer u_buffer (
        .clk         (clk),
        .rst_i       (rst_i),
        .wr_i        (wr),
        .pop_i       (pop),
        .rd_word_i   (rd_word),
        .head_hdr_o  (head_hdr),
        .head_word_o (head_word),
        .count_o     (count),
        .full_o      (full)
    );

endmodule

`default_nettype wire

// ==== sim/udp_rx_assert.sv ====
// Bound to the control block, so only stream handshakes and pulse outputs are visible here
`timescale 1ns/10ps
`default_nettype none

module udp_rx_assert (
    input wire                        clk,
    input wire                        rst_i,
    input wire                        hdr_valid_i,
    input wire                        hdr_ready_o,
    input wire udp_rx_pkg::udp_beat_t beat_i,
    input wire                        beat_valid_i,
    input wire                        beat_ready_o,
    input wire                        drop_o,
    input wire                        rx_irq_o
);

    import udp_rx_pkg::*;

    // Header taken, one decision cycle, then the payload phase opens
    assert property (@(posedge clk) disable iff (rst_i)
        (hdr_valid_i && hdr_ready_o) |=> (!hdr_ready_o && !beat_ready_o) ##1 beat_ready_o)
        else $error("Payload phase did not open two cycles after the header handshake");

    // No stall inside a datagram
    assert property (@(posedge clk) disable iff (rst_i)
        (beat_ready_o && !(beat_valid_i && beat_i.last)) |=> beat_ready_o)
        else $error("Beat ready fell before the last beat was taken");

    assert property (@(posedge clk) disable iff (rst_i) rx_irq_o |=> !rx_irq_o)
        else $error("Interrupt stayed high for more than one cycle");

    // Irq lands one cycle after the last beat handshake
    assert property (@(posedge clk) disable iff (rst_i)
        rx_irq_o |-> $past(beat_valid_i && beat_ready_o && beat_i.last))
        else $error("Interrupt without a last beat handshake in the previous cycle");

    assert property (@(posedge clk) disable iff (rst_i)
        drop_o |-> $past(beat_valid_i && beat_ready_o && beat_i.last))
        else $error("Drop without a last beat handshake in the previous cycle");

    assert property (@(posedge clk) rst_i |=> (!hdr_ready_o && !beat_ready_o && !rx_irq_o))
        else $error("Ready or interrupt high right after reset");

endmodule

`default_nettype wire

// ==== sim/udp_rx_checker.sv ====
// Read expectations must be queued in the same order as the reads are issued
`timescale 1ns/10ps
`default_nettype none

module udp_rx_checker (
    input wire                        clk,
    input wire                        rst_i,
    input wire udp_rx_pkg::axil_req_t axil_req_i,
    input wire udp_rx_pkg::axil_rsp_t axil_rsp_i,
    input wire                        rx_irq_i
);

    import udp_rx_pkg::*;

    // Model queue of expected read data
    logic [31:0] exp_val [$];
    string       exp_name [$];
    logic [31:0] cur_val;
    string       cur_name;
    int          irq_seen;
    int          reads_checked = 0;
    int          mismatches = 0;
    int          irq_errs = 0;
    int          other_errs = 0;

    task automatic expect_read(input string name, input logic [31:0] val);
        exp_name.push_back(name);
        exp_val.push_back(val);
    endtask

    task automatic check_irqs(input int expected);
        if (irq_seen != expected) begin
            irq_errs++;
            $display("[FAIL] t=%0t signal=rx_irq_o count expected=%0d got=%0d",
                     $time, expected, irq_seen);
        end
    endtask

    function automatic int pending_reads();
        return exp_val.size();
    endfunction

    function automatic int error_total();
        return mismatches + irq_errs + other_errs;
    endfunction

    always @(posedge clk) begin
        if (rst_i) begin
            irq_seen <= 0;
        end else begin
            if (rx_irq_i) begin
                irq_seen <= irq_seen + 1;
            end
            // Address and data channels are accepted together
            if (axil_rsp_i.awready !== axil_rsp_i.wready) begin
                other_errs++;
                $display("Write address ready and write data ready differ at t=%0t", $time);
            end
            if (axil_rsp_i.bvalid && axil_req_i.bready && axil_rsp_i.bresp != 2'b00) begin
                other_errs++;
                $display("Write response at t=%0t was not OKAY", $time);
            end
            if (axil_rsp_i.rvalid && axil_req_i.rready) begin
                if (exp_val.size() == 0) begin
                    other_errs++;
                    $display("Read data at t=%0t arrived with no read outstanding", $time);
                end else begin
                    cur_val  = exp_val.pop_front();
                    cur_name = exp_name.pop_front();
                    reads_checked++;
                    if (axil_rsp_i.rresp != 2'b00) begin
                        other_errs++;
                        $display("Read of %s at t=%0t was not OKAY", cur_name, $time);
                    end
                    if (axil_rsp_i.rdata !== cur_val) begin
                        mismatches++;
                        $display("[FAIL] t=%0t signal=%s expected=%h got=%h",
                                 $time, cur_name, cur_val, axil_rsp_i.rdata);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/udp_rx_tb.sv ====
// One datagram in flight at a time; bytes past the UDP length in the last beat are LFSR filler
`timescale 1ns/10ps
`default_nettype none

module udp_rx_tb;

    import udp_rx_pkg::*;

    localparam int          TIMEOUT   = 64;
    localparam int          N_ENT     = 10;
    localparam logic [31:0] HOST_IP   = 32'hC0A8_0A02;
    localparam logic [15:0] HOST_PORT = 16'd5001;

    // One row of the stimulus table
    typedef struct packed {
        udp_hdr_t    hdr;
        logic [15:0] pay_len;
        logic        enable;
        logic        store;
        logic        drain;
    } dgram_t;

    logic        clk;
    logic        rst;
    udp_hdr_t    hdr_d;
    logic        hdr_valid;
    logic        hdr_ready;
    udp_beat_t   beat_d;
    logic        beat_valid;
    logic        beat_ready;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic        rx_irq;

    dgram_t      tbl [N_ENT];
    logic [63:0] pay [N_ENT][16];
    int          stored [$];
    logic [31:0] lfsr_q;
    logic        cur_enable;
    int          irq_exp;
    logic [31:0] drops_exp;
    int          timeouts;
    int          errors;
    int          n;

    udp_rx_top uut (
        .clk          (clk),
        .rst_i        (rst),
        .hdr_i        (hdr_d),
        .hdr_valid_i  (hdr_valid),
        .hdr_ready_o  (hdr_ready),
        .beat_i       (beat_d),
        .beat_valid_i (beat_valid),
        .beat_ready_o (beat_ready),
        .axil_i       (axil_req),
        .axil_o       (axil_rsp),
        .rx_irq_o     (rx_irq)
    );

    udp_rx_checker chk (
        .clk        (clk),
        .rst_i      (rst),
        .axil_req_i (axil_req),
        .axil_rsp_i (axil_rsp),
        .rx_irq_i   (rx_irq)
    );

    bind udp_rx_ctrl udp_rx_assert u_assert (
        .clk          (clk),
        .rst_i        (rst_i),
        .hdr_valid_i  (hdr_valid_i),
        .hdr_ready_o  (hdr_ready_o),
        .beat_i       (beat_i),
        .beat_valid_i (beat_valid_i),
        .beat_ready_o (beat_ready_o),
        .drop_o       (drop_o),
        .rx_irq_o     (rx_irq_o)
    );

    always #5 clk = ~clk;

    // Galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic dgram_t entry(input logic [31:0] sip, input logic [15:0] sport,
                                     input logic [31:0] dip, input logic [15:0] dport,
                                     input logic [15:0] plen, input logic en,
                                     input logic st, input logic dr);
        dgram_t e;
        e.hdr     = '{src_ip: sip, src_port: sport, dst_ip: dip, dst_port: dport,
                      length: plen + 16'd8};
        e.pay_len = plen;
        e.enable  = en;
        e.store   = st;
        e.drain   = dr;
        return e;
    endfunction

    task automatic random_word(output logic [63:0] w);
        for (int b = 0; b < 64; b++) begin
            w[b]   = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("Timeout at t=%0t while waiting for %s", $time, what);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        int k;
        @(posedge clk);
        axil_req.awaddr  <= addr;
        axil_req.awvalid <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hF;
        axil_req.wvalid  <= 1'b1;
        k = 0;
        do begin
            @(posedge clk);
            k++;
        end while (!axil_rsp.awready && k < TIMEOUT);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        if (!axil_rsp.awready) begin
            note_timeout("awready");
            return;
        end
        k = 0;
        do begin
            @(posedge clk);
            k++;
        end while (!axil_rsp.bvalid && k < TIMEOUT);
        if (!axil_rsp.bvalid) begin
            note_timeout("bvalid");
        end
    endtask

    task automatic read_reg(input logic [7:0] addr, input string name, input logic [31:0] exp);
        int k;
        chk.expect_read(name, exp);
        @(posedge clk);
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        k = 0;
        do begin
            @(posedge clk);
            k++;
        end while (!axil_rsp.arready && k < TIMEOUT);
        axil_req.arvalid <= 1'b0;
        if (!axil_rsp.arready) begin
            note_timeout("arready");
            return;
        end
        k = 0;
        do begin
            @(posedge clk);
            k++;
        end while (!axil_rsp.rvalid && k < TIMEOUT);
        if (!axil_rsp.rvalid) begin
            note_timeout("rvalid");
        end
    endtask

    task automatic send_datagram(input int idx);
        int          k;
        int          nbeats;
        logic [63:0] w;
        // Zero payload still sends one beat
        nbeats = (int'(tbl[idx].pay_len) + 7) / 8;
        if (nbeats == 0) begin
            nbeats = 1;
        end
        for (int i = 0; i < nbeats; i++) begin
            random_word(w);
            pay[idx][i] = w;
        end
        @(posedge clk);
        hdr_d     <= tbl[idx].hdr;
        hdr_valid <= 1'b1;
        k = 0;
        do begin
            @(posedge clk);
            k++;
        end while (!hdr_ready && k < TIMEOUT);
        hdr_valid <= 1'b0;
        if (!hdr_ready) begin
            note_timeout("hdr_ready_o");
            return;
        end
        for (int i = 0; i < nbeats; i++) begin
            beat_d.data <= pay[idx][i];
            beat_d.last <= (i == nbeats - 1);
            beat_valid  <= 1'b1;
            k = 0;
            do begin
                @(posedge clk);
                k++;
            end while (!beat_ready && k < TIMEOUT);
            if (!beat_ready) begin
                beat_valid <= 1'b0;
                note_timeout("beat_ready_o");
                return;
            end
        end
        beat_valid <= 1'b0;
    endtask

    // Check every stored datagram at the head, oldest first, then release it
    task automatic drain_slots();
        int idx;
        int words;
        while (stored.size() > 0) begin
            idx = stored.pop_front();
            read_reg(HEAD_SRC_IP, "HEAD_SRC_IP", tbl[idx].hdr.src_ip);
            read_reg(HEAD_PORTS, "HEAD_PORTS", {tbl[idx].hdr.src_port, tbl[idx].hdr.dst_port});
            read_reg(HEAD_LEN, "HEAD_LEN", 32'(tbl[idx].hdr.length));
            words = (int'(tbl[idx].pay_len) + 7) / 8;
            for (int w = 0; w < words; w++) begin
                read_reg(8'(int'(DATA) + 8 * w), $sformatf("DATA[%0d] low", w),
                         pay[idx][w][31:0]);
                read_reg(8'(int'(DATA) + 8 * w + 4), $sformatf("DATA[%0d] high", w),
                         pay[idx][w][63:32]);
            end
            write_reg(POP, 32'd1);
            read_reg(STATUS, "STATUS", 32'(stored.size()));
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        <= 1'b1;
        hdr_d      <= '0;
        hdr_valid  <= 1'b0;
        beat_d     <= '0;
        beat_valid <= 1'b0;
        axil_req   <= '0;
        lfsr_q     = 32'h92b1;
        cur_enable = 1'b1;
        irq_exp    = 0;
        drops_exp  = '0;
        timeouts   = 0;

        // Single datagram, checked and popped right away
        tbl[0] = entry(32'h0A00_0005, 16'd1234, HOST_IP, HOST_PORT, 16'd20, 1'b1, 1'b1, 1'b1);
        // Wrong port, wrong IP, disabled, oversize
        tbl[1] = entry(32'h0A00_0006, 16'd2000, HOST_IP, 16'd5002, 16'd16, 1'b1, 1'b0, 1'b0);
        tbl[2] = entry(32'h0A00_0007, 16'd2001, 32'hC0A8_0A03, HOST_PORT, 16'd8, 1'b1, 1'b0,
                       1'b0);
        tbl[3] = entry(32'h0A00_0008, 16'd2002, HOST_IP, HOST_PORT, 16'd24, 1'b0, 1'b0, 1'b0);
        tbl[4] = entry(32'h0A00_0009, 16'd2003, HOST_IP, HOST_PORT, 16'd72, 1'b1, 1'b0, 1'b0);
        // Fill all four slots, the fifth finds the ring full
        tbl[5] = entry(32'h0A00_000A, 16'd3000, HOST_IP, HOST_PORT, 16'd0, 1'b1, 1'b1, 1'b0);
        tbl[6] = entry(32'h0A00_000B, 16'd3001, HOST_IP, HOST_PORT, 16'd64, 1'b1, 1'b1, 1'b0);
        tbl[7] = entry(32'h0A00_000C, 16'd3002, HOST_IP, HOST_PORT, 16'd36, 1'b1, 1'b1, 1'b0);
        tbl[8] = entry(32'h0A00_000D, 16'd3003, HOST_IP, HOST_PORT, 16'd17, 1'b1, 1'b1, 1'b0);
        tbl[9] = entry(32'h0A00_000E, 16'd3004, HOST_IP, HOST_PORT, 16'd40, 1'b1, 1'b0, 1'b1);

        repeat (3) @(posedge clk);
        rst             <= 1'b0;
        axil_req.bready <= 1'b1;
        axil_req.rready <= 1'b1;

        read_reg(STATUS, "STATUS", 32'd0);
        read_reg(DROPS, "DROPS", 32'd0);
        write_reg(CTRL, {HOST_PORT, 15'd0, 1'b1});
        write_reg(LOCAL_IP, HOST_IP);
        read_reg(CTRL, "CTRL", {HOST_PORT, 15'd0, 1'b1});
        read_reg(LOCAL_IP, "LOCAL_IP", HOST_IP);
        chk.check_irqs(0);

        for (int i = 0; i < N_ENT; i++) begin
            if (tbl[i].enable != cur_enable) begin
                write_reg(CTRL, {HOST_PORT, 15'd0, tbl[i].enable});
                cur_enable = tbl[i].enable;
            end
            send_datagram(i);
            if (tbl[i].store) begin
                stored.push_back(i);
                irq_exp++;
                n = 0;
                do begin
                    @(posedge clk);
                    n++;
                end while (!rx_irq && n < TIMEOUT);
                if (!rx_irq) begin
                    note_timeout("rx_irq_o");
                end
            end else begin
                drops_exp = drops_exp + 32'd1;
                // Drop counter moves one cycle after the last beat
                repeat (2) @(posedge clk);
            end
            read_reg(STATUS, "STATUS", 32'(stored.size()));
            read_reg(DROPS, "DROPS", drops_exp);
            chk.check_irqs(irq_exp);
            if (tbl[i].drain) begin
                drain_slots();
            end
        end
        repeat (4) @(posedge clk);

        errors = chk.error_total() + timeouts + chk.pending_reads();
        $display("Reads checked: %0d, errors: %0d, timeouts: %0d, unanswered reads: %0d",
                 chk.reads_checked, chk.error_total(), timeouts, chk.pending_reads());
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+source
source/udp_rx_pkg.sv
source/udp_rx_csr.sv
source/udp_rx_ctrl.sv
source/udp_rx_buffer.sv
source/udp_rx_top.sv
sim/udp_rx_assert.sv
sim/udp_rx_checker.sv
sim/udp_rx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module udp_rx_tb -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vudp_rx_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
